//--- all.f
hw/id_pkg.sv
hw/id_pipe_reg.sv
hw/id_decoder.sv
hw/id_gpr_file.sv
hw/id_hazard_check.sv
hw/id_branch_unit.sv
hw/id_stage.sv
testbench/tb_id_assert.sv
testbench/tb_id_stage.sv

//--- testbench/tb_id_stage.sv
// row-driven test of id_stage; every register is written before the rows run, stops at first error
`timescale 1ns/1ps

module tb_id_stage;

  import id_pkg::*;

  localparam int MAX_ROWS = 24;
  localparam int SETTLE   = 5;  // ns after the falling edge

  logic      i_clk;
  logic      i_arst_n;
  logic      i_fs_valid;
  inst_t     i_fs_inst;
  pc_t       i_fs_pc;
  logic      o_ds_allowin;
  logic      o_es_valid;
  pc_t       o_es_pc;
  xlen_t     o_es_rs1_data;
  xlen_t     o_es_rs2_data;
  xlen_t     o_es_imm;
  gpr_addr_t o_es_rd;
  alu_op_t   o_es_alu_op;
  logic      o_es_alu_src1_sel;
  logic [1:0] o_es_alu_src2_sel;
  logic      o_es_gpr_wen;
  logic      o_es_mem_ren;
  logic      o_es_mem_wen;
  mem_op_t   o_es_mem_op;
  logic      o_es_invalid;
  logic      i_es_allowin;
  logic      o_br_taken;
  pc_t       o_br_target;
  gpr_addr_t i_es_rd;
  gpr_addr_t i_ms_rd;
  gpr_addr_t i_ws_rd;
  logic      i_ws_wen;
  gpr_addr_t i_ws_waddr;
  xlen_t     i_ws_wdata;

  string       row_name  [MAX_ROWS];
  logic        row_write [MAX_ROWS];  // write rows keep the register index in row_inst
  inst_t       row_inst  [MAX_ROWS];
  pc_t         row_pc    [MAX_ROWS];
  logic [14:0] row_haz   [MAX_ROWS];  // {es_rd, ms_rd, ws_rd}
  logic        row_allow [MAX_ROWS];
  logic        row_valid [MAX_ROWS];  // low means a stall is expected first
  xlen_t       row_imm   [MAX_ROWS];
  gpr_addr_t   row_rd    [MAX_ROWS];
  alu_op_t     row_alu   [MAX_ROWS];
  logic [5:0]  row_flags [MAX_ROWS];  // src1_sel, src2_sel, gpr_wen, mem_ren, mem_wen
  logic        row_inv   [MAX_ROWS];

  xlen_t       shadow [NUM_GPR];
  logic [15:0] lfsr;
  int          n_rows = 0;
  int          cycles = 0;
  int          cycle_limit = 0;
  string       cur_test;

  id_stage dut0 (.*);

  initial i_clk = 1'b0;
  always #20 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit)
      fail_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_xlen(input string what, input xlen_t exp, input xlen_t act);
    if (act !== exp)
      fail_run($sformatf("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act));
  endtask

  task automatic check_pc(input string what, input pc_t exp, input pc_t act);
    if (act !== exp)
      fail_run($sformatf("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act));
  endtask

  task automatic check_addr(input string what, input gpr_addr_t exp, input gpr_addr_t act);
    if (act !== exp)
      fail_run($sformatf("[ERROR] %s %s: expected %0d, actual %0d", cur_test, what, exp, act));
  endtask

  task automatic check_alu(input string what, input alu_op_t exp, input alu_op_t act);
    if (act !== exp)
      fail_run($sformatf("[ERROR] %s %s: expected %0d, actual %0d", cur_test, what, exp, act));
  endtask

  task automatic check_memop(input string what, input mem_op_t exp, input mem_op_t act);
    if (act !== exp)
      fail_run($sformatf("[ERROR] %s %s: expected %b, actual %b", cur_test, what, exp, act));
  endtask

  task automatic check_sel(input string what, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp)
      fail_run($sformatf("[ERROR] %s %s: expected %b, actual %b", cur_test, what, exp, act));
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp)
      fail_run($sformatf("[ERROR] %s %s: expected %b, actual %b", cur_test, what, exp, act));
  endtask

  // galois form, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand64(output xlen_t v);
    for (int i = 0; i < XLEN; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // instruction formats as in the isa manual
  function automatic inst_t enc_r(int f7, int rs2, int rs1, int f3, int rd, logic [6:0] opc);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic inst_t enc_i(int imm, int rs1, int f3, int rd, logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic inst_t enc_s(int imm, int rs2, int rs1, int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], OPC_STORE};
  endfunction

  function automatic inst_t enc_b(int imm, int rs2, int rs1, int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic inst_t enc_u(int imm20, int rd, logic [6:0] opc);
    return {imm20[19:0], rd[4:0], opc};
  endfunction

  function automatic inst_t enc_j(int imm, int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
  endfunction

  function automatic logic expect_taken(input inst_t ins, input xlen_t a, input xlen_t b);
    if (ins[6:0] == OPC_JAL || ins[6:0] == OPC_JALR)
      return 1'b1;
    if (ins[6:0] != OPC_BRANCH)
      return 1'b0;
    case (ins[14:12])
      3'b000:  return a == b;  // beq
      3'b001:  return a != b;  // bne
      3'b110:  return a < b;   // bltu
      default: return 1'b0;
    endcase
  endfunction

  task automatic add_row(input string name, input inst_t ins, input pc_t pc,
                         input logic [14:0] haz, input logic allow, input logic valid,
                         input xlen_t imm, input gpr_addr_t rd, input alu_op_t alu,
                         input logic [5:0] flags, input logic inv);
    row_name[n_rows]  = name;
    row_write[n_rows] = 1'b0;
    row_inst[n_rows]  = ins;
    row_pc[n_rows]    = pc;
    row_haz[n_rows]   = haz;
    row_allow[n_rows] = allow;
    row_valid[n_rows] = valid;
    row_imm[n_rows]   = imm;
    row_rd[n_rows]    = rd;
    row_alu[n_rows]   = alu;
    row_flags[n_rows] = flags;
    row_inv[n_rows]   = inv;
    n_rows++;
  endtask

  task automatic add_write(input string name, input int idx);
    row_name[n_rows]  = name;
    row_write[n_rows] = 1'b1;
    row_inst[n_rows]  = inst_t'(idx);
    n_rows++;
  endtask

  task automatic build_table();
    add_write("write x5", 5);
    add_write("write x6", 6);
    add_write("write x7", 7);
    add_write("write x0", 0);
    add_row("add reads", enc_r(0, 6, 5, 0, 3, OPC_OP), 'h100, '0, 1, 1,
            0, 3, ALU_ADD, 6'b000100, 0);
    add_row("x0 read", enc_r(0, 5, 0, 0, 3, OPC_OP), 'h104, '0, 1, 1,
            0, 3, ALU_ADD, 6'b000100, 0);
    add_row("addi imm", enc_i(-20, 5, 0, 4, OPC_OP_IMM), 'h108, '0, 1, 1,
            -20, 4, ALU_ADD, 6'b001100, 0);
    add_row("lui imm", enc_u(32'h80001, 6, OPC_LUI), 'h10c, '0, 1, 1,
            64'hFFFF_FFFF_8000_1000, 6, ALU_COPY2, 6'b001100, 0);
    add_row("auipc imm", enc_u(32'h12, 7, OPC_AUIPC), 'h1000, '0, 1, 1,
            64'h12000, 7, ALU_ADD, 6'b101100, 0);
    add_row("ld imm", enc_i(16, 5, 3, 8, OPC_LOAD), 'h1004, '0, 1, 1,
            16, 8, ALU_ADD, 6'b001110, 0);
    add_row("sd imm", enc_s(-8, 6, 5, 3), 'h1008, '0, 1, 1,
            -8, 0, ALU_ADD, 6'b001001, 0);
    add_row("beq taken", enc_b(64, 5, 5, 0), 'h2000, '0, 1, 1,
            64, 0, ALU_ADD, 6'b000000, 0);
    add_row("beq not taken", enc_b(-32, 6, 5, 0), 'h2100, '0, 1, 1,
            -32, 0, ALU_ADD, 6'b000000, 0);
    add_row("bltu x5 x6", enc_b(128, 6, 5, 6), 'h2200, '0, 1, 1,
            128, 0, ALU_ADD, 6'b000000, 0);
    add_row("bltu x6 x5", enc_b(128, 5, 6, 6), 'h2300, '0, 1, 1,
            128, 0, ALU_ADD, 6'b000000, 0);
    add_row("jal target", enc_j(2048, 1), 'h3000, '0, 1, 1,
            2048, 1, ALU_ADD, 6'b110100, 0);
    add_row("jalr target", enc_i(13, 5, 0, 1, OPC_JALR), 'h3100, '0, 1, 1,
            13, 1, ALU_ADD, 6'b110100, 0);
    add_row("raw stall", enc_b(16, 7, 5, 1), 'h4000, {5'd0, 5'd7, 5'd0}, 1, 0,
            16, 0, ALU_ADD, 6'b000000, 0);
    add_row("zero dest", enc_i(5, 0, 0, 9, OPC_OP_IMM), 'h4004, {5'd0, 5'd0, 5'd12}, 1, 1,
            5, 9, ALU_ADD, 6'b001100, 0);
    add_row("back-pressure", enc_r(0, 6, 5, 0, 10, OPC_OP), 'h4008, '0, 0, 1,
            0, 10, ALU_ADD, 6'b000100, 0);
    add_row("invalid opcode", 32'h0062_8AFF, 'h400c, '0, 1, 1,
            0, 0, ALU_ADD, 6'b000000, 1);
  endtask

  task automatic write_reg(input gpr_addr_t a, input xlen_t d);
    @(negedge i_clk);
    i_ws_wen     = 1'b1;
    i_ws_waddr   = a;
    i_ws_wdata   = d;
    i_es_allowin = 1'b1;
    @(negedge i_clk);
    i_ws_wen = 1'b0;
    if (a != '0)
      shadow[a] = d;
  endtask

  task automatic check_fields(input int r);
    inst_t ins;
    xlen_t rs1v;
    xlen_t rs2v;
    pc_t   target;
    logic  taken;
    ins  = row_inst[r];
    rs1v = shadow[ins[19:15]];
    rs2v = shadow[ins[24:20]];
    taken = expect_taken(ins, rs1v, rs2v);
    if (ins[6:0] == OPC_JALR) begin
      target    = rs1v + row_imm[r];
      target[0] = 1'b0;
    end else begin
      target = row_pc[r] + row_imm[r];
    end
    check_flag("es_valid", 1'b1, o_es_valid);
    check_pc("es_pc", row_pc[r], o_es_pc);
    check_xlen("rs1_data", rs1v, o_es_rs1_data);
    check_xlen("rs2_data", rs2v, o_es_rs2_data);
    check_xlen("imm", row_imm[r], o_es_imm);
    check_addr("rd", row_rd[r], o_es_rd);
    check_alu("alu_op", row_alu[r], o_es_alu_op);
    check_flag("src1_sel", row_flags[r][5], o_es_alu_src1_sel);
    check_sel("src2_sel", row_flags[r][4:3], o_es_alu_src2_sel);
    check_flag("gpr_wen", row_flags[r][2], o_es_gpr_wen);
    check_flag("mem_ren", row_flags[r][1], o_es_mem_ren);
    check_flag("mem_wen", row_flags[r][0], o_es_mem_wen);
    check_memop("mem_op", ins[14:12], o_es_mem_op);
    check_flag("invalid", row_inv[r], o_es_invalid);
    check_flag("br_taken", taken, o_br_taken);
    if (taken)
      check_pc("br_target", target, o_br_target);
  endtask

  task automatic run_issue(input int r);
    @(negedge i_clk);
    i_fs_valid   = 1'b1;
    i_fs_inst    = row_inst[r];
    i_fs_pc      = row_pc[r];
    {i_es_rd, i_ms_rd, i_ws_rd} = '0;
    i_es_allowin = 1'b1;  // lets the previous instruction leave
    #(SETTLE);
    while (!o_ds_allowin) begin
      @(negedge i_clk);
      #(SETTLE);
    end
    @(negedge i_clk);  // taken at the rising edge just passed
    i_fs_valid   = 1'b0;
    {i_es_rd, i_ms_rd, i_ws_rd} = row_haz[r];
    i_es_allowin = row_allow[r];
    #(SETTLE);
    if (!row_valid[r]) begin
      check_flag("es_valid in stall", 1'b0, o_es_valid);
      check_flag("br_taken in stall", 1'b0, o_br_taken);
      check_flag("ds_allowin in stall", 1'b0, o_ds_allowin);
      @(negedge i_clk);
      {i_es_rd, i_ms_rd, i_ws_rd} = '0;
      #(SETTLE);
    end
    check_fields(r);
    if (!row_allow[r]) begin
      check_flag("ds_allowin held", 1'b0, o_ds_allowin);
      @(negedge i_clk);
      #(SETTLE);
      check_fields(r);  // one more cycle of back-pressure
      check_flag("ds_allowin held", 1'b0, o_ds_allowin);
    end
  endtask

  initial begin
    xlen_t data;
    i_arst_n     = 1'b0;
    i_fs_valid   = 1'b0;
    i_fs_inst    = '0;
    i_fs_pc      = '0;
    i_es_allowin = 1'b1;
    i_es_rd      = '0;
    i_ms_rd      = '0;
    i_ws_rd      = '0;
    i_ws_wen     = 1'b0;
    i_ws_waddr   = '0;
    i_ws_wdata   = '0;
    lfsr         = 16'd63137;
    shadow[0]    = '0;
    build_table();
    cycle_limit = n_rows * 8 + 16 + NUM_GPR * 2;
    cur_test = "reset";
    repeat (16) @(negedge i_clk);
    i_arst_n = 1'b1;
    #(SETTLE);
    check_flag("es_valid", 1'b0, o_es_valid);
    check_flag("br_taken", 1'b0, o_br_taken);
    check_flag("ds_allowin", 1'b1, o_ds_allowin);
    cur_test = "register fill";
    for (int a = 1; a < NUM_GPR; a++) begin
      rand64(data);
      write_reg(gpr_addr_t'(a), data);
    end
    for (int r = 0; r < n_rows; r++) begin
      cur_test = row_name[r];
      if (row_write[r]) begin
        rand64(data);
        write_reg(row_inst[r][4:0], data);
      end else begin
        run_issue(r);
      end
    end
    $display("Done: no errors");
    $finish;
  end

endmodule

//--- testbench/tb_id_assert.sv
// handshake and redirect properties for id_stage; sampled at the rising edge, off during reset
`timescale 1ns/1ps

module id_stage_assert (
  input logic          i_clk,
  input logic          i_arst_n,
  input logic          i_fs_valid,
  input logic          i_es_valid,
  input logic          i_es_allowin,
  input logic          i_ds_allowin,
  input logic          i_br_taken,
  input id_pkg::inst_t i_ds_inst,
  input id_pkg::pc_t   i_es_pc,
  input id_pkg::xlen_t i_es_imm
);

  import id_pkg::*;

  // only a jump or a conditional branch redirects, and only while handed over
  taken_needs_valid: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_br_taken |-> (i_es_valid && (i_ds_inst[6:0] == OPC_JAL
                                   || i_ds_inst[6:0] == OPC_JALR
                                   || i_ds_inst[6:0] == OPC_BRANCH)))
    else $error("redirect raised without a valid branch or jump handover");

  // execute not accepting, so the slot must not move
  hold_under_backpressure: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_es_valid && !i_es_allowin) |=> ($stable(i_es_pc) && $stable(i_es_imm)))
    else $error("pc or immediate changed while execute was not accepting");

  // nothing taken in at this edge leaves the stage empty
  empty_allows_in: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (i_ds_allowin && !i_fs_valid) |=> (!i_es_valid && i_ds_allowin))
    else $error("empty stage refused fetch");

endmodule

bind id_stage id_stage_assert u_assert (
  .i_clk        (i_clk),
  .i_arst_n     (i_arst_n),
  .i_fs_valid   (i_fs_valid),
  .i_es_valid   (o_es_valid),
  .i_es_allowin (i_es_allowin),
  .i_ds_allowin (o_ds_allowin),
  .i_br_taken   (o_br_taken),
  .i_ds_inst    (ds_inst),
  .i_es_pc      (o_es_pc),
  .i_es_imm     (o_es_imm)
);

//--- hw/id_stage.sv
// decode stage top; no bypass network, raw hazards stall until writeback has retired the writer
`timescale 1ns/1ps

module id_stage (
  input  logic                i_clk,
  input  logic                i_arst_n,
  // from fetch
  input  logic                i_fs_valid,
  input  id_pkg::inst_t       i_fs_inst,
  input  id_pkg::pc_t         i_fs_pc,
  output logic                o_ds_allowin,
  // to execute
  output logic                o_es_valid,
  output id_pkg::pc_t         o_es_pc,
  output id_pkg::xlen_t       o_es_rs1_data,
  output id_pkg::xlen_t       o_es_rs2_data,
  output id_pkg::xlen_t       o_es_imm,
  output id_pkg::gpr_addr_t   o_es_rd,
  output id_pkg::alu_op_t     o_es_alu_op,
  output logic                o_es_alu_src1_sel,
  output logic [1:0]          o_es_alu_src2_sel,
  output logic                o_es_gpr_wen,
  output logic                o_es_mem_ren,
  output logic                o_es_mem_wen,
  output id_pkg::mem_op_t     o_es_mem_op,
  output logic                o_es_invalid,
  input  logic                i_es_allowin,
  // redirect to fetch
  output logic                o_br_taken,
  output id_pkg::pc_t         o_br_target,
  // downstream destinations
  input  id_pkg::gpr_addr_t   i_es_rd,
  input  id_pkg::gpr_addr_t   i_ms_rd,
  input  id_pkg::gpr_addr_t   i_ws_rd,
  // writeback port
  input  logic                i_ws_wen,
  input  id_pkg::gpr_addr_t   i_ws_waddr,
  input  id_pkg::xlen_t       i_ws_wdata
);

  import id_pkg::*;

  inst_t     ds_inst;
  gpr_addr_t rs1;
  gpr_addr_t rs2;
  logic      ready_go;
  logic      br_en;
  br_func_t  br_func;

  id_pipe_reg u_pipe_reg (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_fs_valid   (i_fs_valid),
    .i_fs_inst    (i_fs_inst),
    .i_fs_pc      (i_fs_pc),
    .i_ready_go   (ready_go),
    .i_es_allowin (i_es_allowin),
    .o_ds_allowin (o_ds_allowin),
    .o_valid      (o_es_valid),
    .o_inst       (ds_inst),
    .o_pc         (o_es_pc)
  );

  id_decoder u_decoder (
    .i_inst         (ds_inst),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_rd           (o_es_rd),
    .o_imm          (o_es_imm),
    .o_alu_op       (o_es_alu_op),
    .o_alu_src1_sel (o_es_alu_src1_sel),
    .o_alu_src2_sel (o_es_alu_src2_sel),
    .o_gpr_wen      (o_es_gpr_wen),
    .o_mem_ren      (o_es_mem_ren),
    .o_mem_wen      (o_es_mem_wen),
    .o_mem_op       (o_es_mem_op),
    .o_br_en        (br_en),
    .o_br_func      (br_func),
    .o_invalid      (o_es_invalid)
  );

  id_gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_waddr  (i_ws_waddr),
    .i_wen    (i_ws_wen),
    .i_wdata  (i_ws_wdata),
    .o_rdata1 (o_es_rs1_data),
    .o_rdata2 (o_es_rs2_data)
  );

  id_hazard_check u_hazard_check (
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_es_rd    (i_es_rd),
    .i_ms_rd    (i_ms_rd),
    .i_ws_rd    (i_ws_rd),
    .o_ready_go (ready_go)
  );

  // qualified by the handover valid, so a stalled slot never redirects
  id_branch_unit u_branch_unit (
    .i_valid     (o_es_valid),
    .i_br_en     (br_en),
    .i_br_func   (br_func),
    .i_pc        (o_es_pc),
    .i_imm       (o_es_imm),
    .i_rs1_data  (o_es_rs1_data),
    .i_rs2_data  (o_es_rs2_data),
    .o_br_taken  (o_br_taken),
    .o_br_target (o_br_target)
  );

endmodule

//--- hw/id_branch_unit.sv
// branch resolution in decode; taken is only raised for an instruction being handed over
`timescale 1ns/1ps

module id_branch_unit (
  input  logic             i_valid,
  input  logic             i_br_en,
  input  id_pkg::br_func_t i_br_func,
  input  id_pkg::pc_t      i_pc,
  input  id_pkg::xlen_t    i_imm,
  input  id_pkg::xlen_t    i_rs1_data,
  input  id_pkg::xlen_t    i_rs2_data,
  output logic             o_br_taken,
  output id_pkg::pc_t      o_br_target
);

  import id_pkg::*;

  logic eq;
  logic lt;
  logic ltu;
  logic cond;

  assign eq  = (i_rs1_data == i_rs2_data);
  assign lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign ltu = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_br_func)
      BR_BEQ:  cond = eq;
      BR_BNE:  cond = !eq;
      BR_BLT:  cond = lt;
      BR_BGE:  cond = !lt;
      BR_BLTU: cond = ltu;
      BR_BGEU: cond = !ltu;
      default: cond = 1'b1;  // jal, jalr
    endcase
  end

  assign o_br_taken  = i_valid && i_br_en && cond;
  assign o_br_target = (i_br_func == BR_JALR) ? ((i_rs1_data + i_imm) & ~pc_t'(1))
                                              : (i_pc + i_imm);

endmodule

//--- hw/id_hazard_check.sv
// raw interlock against ex/mem/wb destinations; a zero destination means no pending writer
`timescale 1ns/1ps

module id_hazard_check (
  input  id_pkg::gpr_addr_t i_rs1,
  input  id_pkg::gpr_addr_t i_rs2,
  input  id_pkg::gpr_addr_t i_es_rd,
  input  id_pkg::gpr_addr_t i_ms_rd,
  input  id_pkg::gpr_addr_t i_ws_rd,
  output logic              o_ready_go
);

  import id_pkg::*;

  function automatic logic dest_hit(gpr_addr_t rd, gpr_addr_t rs1, gpr_addr_t rs2);
    return (rd != '0) && (rd == rs1 || rd == rs2);
  endfunction

  // wait for writeback to clear, no bypass
  assign o_ready_go = !(dest_hit(i_es_rd, i_rs1, i_rs2)
                     || dest_hit(i_ms_rd, i_rs1, i_rs2)
                     || dest_hit(i_ws_rd, i_rs1, i_rs2));

endmodule

//--- hw/id_gpr_file.sv
// 32 x 64 register file; array has no reset, read before first write returns x
`timescale 1ns/1ps

module id_gpr_file (
  input  logic              i_clk,
  input  id_pkg::gpr_addr_t i_raddr1,
  input  id_pkg::gpr_addr_t i_raddr2,
  input  id_pkg::gpr_addr_t i_waddr,
  input  logic              i_wen,
  input  id_pkg::xlen_t     i_wdata,
  output id_pkg::xlen_t     o_rdata1,
  output id_pkg::xlen_t     o_rdata2
);

  import id_pkg::*;

  xlen_t gpr [NUM_GPR];

  always_ff @(posedge i_clk) begin
    if (i_wen && i_waddr != '0) begin  // x0 never stored
      gpr[i_waddr] <= i_wdata;
    end
  end

  // x0 reads as zero
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : gpr[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : gpr[i_raddr2];

endmodule

//--- hw/id_decoder.sv
// rv64i subset decoder; anything outside the subset flags invalid with all enables cleared
`timescale 1ns/1ps

module id_decoder (
  input  id_pkg::inst_t     i_inst,
  output id_pkg::gpr_addr_t o_rs1,
  output id_pkg::gpr_addr_t o_rs2,
  output id_pkg::gpr_addr_t o_rd,
  output id_pkg::xlen_t     o_imm,
  output id_pkg::alu_op_t   o_alu_op,
  output logic              o_alu_src1_sel,
  output logic [1:0]        o_alu_src2_sel,
  output logic              o_gpr_wen,
  output logic              o_mem_ren,
  output logic              o_mem_wen,
  output id_pkg::mem_op_t   o_mem_op,
  output logic              o_br_en,
  output id_pkg::br_func_t  o_br_func,
  output logic              o_invalid
);

  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  alu_op_t    f3_op;
  logic       f3_ok;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  // fixed field positions, decoded whether used or not
  assign o_rs1    = i_inst[19:15];
  assign o_rs2    = i_inst[24:20];
  assign o_rd     = o_gpr_wen ? i_inst[11:7] : '0;
  assign o_mem_op = funct3;

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // funct3 map shared by op and op-imm; shifts are not in the subset
  always_comb begin
    f3_ok = 1'b1;
    case (funct3)
      3'b000:  f3_op = ALU_ADD;
      3'b010:  f3_op = ALU_SLT;
      3'b011:  f3_op = ALU_SLTU;
      3'b100:  f3_op = ALU_XOR;
      3'b110:  f3_op = ALU_OR;
      3'b111:  f3_op = ALU_AND;
      default: begin
        f3_op = ALU_ADD;
        f3_ok = 1'b0;
      end
    endcase
  end

  always_comb begin
    o_imm          = '0;
    o_alu_op       = ALU_ADD;
    o_alu_src1_sel = 1'b0;   // rs1
    o_alu_src2_sel = 2'd0;   // rs2
    o_gpr_wen      = 1'b0;
    o_mem_ren      = 1'b0;
    o_mem_wen      = 1'b0;
    o_br_en        = 1'b0;
    o_br_func      = br_func_t'(funct3);
    o_invalid      = 1'b0;
    case (opcode)
      OPC_LUI: begin
        o_imm          = imm_u;
        o_alu_op       = ALU_COPY2;
        o_alu_src2_sel = 2'd1;
        o_gpr_wen      = 1'b1;
      end
      OPC_AUIPC: begin
        o_imm          = imm_u;
        o_alu_src1_sel = 1'b1;
        o_alu_src2_sel = 2'd1;
        o_gpr_wen      = 1'b1;
      end
      OPC_JAL: begin
        o_imm          = imm_j;
        o_alu_src1_sel = 1'b1;
        o_alu_src2_sel = 2'd2;  // link is pc + 4
        o_gpr_wen      = 1'b1;
        o_br_en        = 1'b1;
        o_br_func      = BR_JAL;
      end
      OPC_JALR: begin
        o_imm          = imm_i;
        o_alu_src1_sel = 1'b1;
        o_alu_src2_sel = 2'd2;
        o_gpr_wen      = 1'b1;
        o_br_en        = 1'b1;
        o_br_func      = BR_JALR;
        o_invalid      = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        o_imm     = imm_b;
        o_br_en   = 1'b1;
        o_invalid = (funct3 == BR_JAL) || (funct3 == BR_JALR);  // 010, 011 unused
      end
      OPC_OP_IMM: begin
        o_imm          = imm_i;
        o_alu_op       = f3_op;
        o_alu_src2_sel = 2'd1;
        o_gpr_wen      = 1'b1;
        o_invalid      = !f3_ok;
      end
      OPC_OP: begin
        o_gpr_wen = 1'b1;
        if (funct7 == 7'b0000000) begin
          o_alu_op  = f3_op;
          o_invalid = !f3_ok;
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          o_alu_op = ALU_SUB;
        end else begin
          o_invalid = 1'b1;
        end
      end
      OPC_LOAD: begin
        o_imm          = imm_i;
        o_alu_src2_sel = 2'd1;
        o_gpr_wen      = 1'b1;
        o_mem_ren      = 1'b1;
        o_invalid      = (funct3 != 3'b011);  // ld only
      end
      OPC_STORE: begin
        o_imm          = imm_s;
        o_alu_src2_sel = 2'd1;
        o_mem_wen      = 1'b1;
        o_invalid      = (funct3 != 3'b011);  // sd only
      end
      default: o_invalid = 1'b1;
    endcase
    if (o_invalid) begin
      o_gpr_wen = 1'b0;
      o_mem_ren = 1'b0;
      o_mem_wen = 1'b0;
      o_br_en   = 1'b0;
    end
  end

endmodule

//--- hw/id_pipe_reg.sv
// fetch-to-decode register; o_valid already includes ready_go, data loads only on a transfer
`timescale 1ns/1ps

module id_pipe_reg (
  input  logic          i_clk,
  input  logic          i_arst_n,
  input  logic          i_fs_valid,
  input  id_pkg::inst_t i_fs_inst,
  input  id_pkg::pc_t   i_fs_pc,
  input  logic          i_ready_go,
  input  logic          i_es_allowin,
  output logic          o_ds_allowin,
  output logic          o_valid,
  output id_pkg::inst_t o_inst,
  output id_pkg::pc_t   o_pc
);

  import id_pkg::*;

  logic ds_valid;

  assign o_ds_allowin = !ds_valid || (i_ready_go && i_es_allowin);
  assign o_valid      = ds_valid && i_ready_go;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_valid;  // empties when fetch has nothing
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_inst <= '0;
      o_pc   <= '0;
    end else if (i_fs_valid && o_ds_allowin) begin
      o_inst <= i_fs_inst;
      o_pc   <= i_fs_pc;
    end
  end

endmodule

//--- hw/id_pkg.sv
// shared widths and codes for the decode stage; only the rv64i subset listed here is decoded
package id_pkg;

  localparam int XLEN    = 64;
  localparam int NUM_GPR = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [XLEN-1:0] pc_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      gpr_addr_t;
  typedef logic [3:0]      alu_op_t;
  typedef logic [2:0]      br_func_t;
  typedef logic [2:0]      mem_op_t;   // same encoding as funct3

  // major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // alu operations
  localparam alu_op_t ALU_ADD   = 4'd0;
  localparam alu_op_t ALU_SUB   = 4'd1;
  localparam alu_op_t ALU_AND   = 4'd2;
  localparam alu_op_t ALU_OR    = 4'd3;
  localparam alu_op_t ALU_XOR   = 4'd4;
  localparam alu_op_t ALU_SLT   = 4'd5;
  localparam alu_op_t ALU_SLTU  = 4'd6;
  localparam alu_op_t ALU_COPY2 = 4'd7;  // operand 2 straight through, lui

  // conditional codes match funct3, jumps use the two unused slots
  localparam br_func_t BR_BEQ  = 3'b000;
  localparam br_func_t BR_BNE  = 3'b001;
  localparam br_func_t BR_JAL  = 3'b010;
  localparam br_func_t BR_JALR = 3'b011;
  localparam br_func_t BR_BLT  = 3'b100;
  localparam br_func_t BR_BGE  = 3'b101;
  localparam br_func_t BR_BLTU = 3'b110;
  localparam br_func_t BR_BGEU = 3'b111;

endpackage
